/* files.f */
fq_pkg.sv
fq_event_capture.sv
fq_record_builder.sv
fq_mem_writer.sv
fq_ctrl.sv
fq_handler.sv
fq_handler_assert.sv
tb_fq_handler.sv

/* fq_ctrl.sv */
`timescale 1ns/100ps

module fq_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [fq_pkg::PPNW-1:0]  fq_base_ppn_i,
    input  logic [4:0]               fq_size_i,    // log2(entries) - 1
    input  logic                     fq_en_i,
    input  logic                     fq_ie_i,
    input  logic [31:0]              fq_head_i,
    input  logic [31:0]              fq_tail_i,
    input  logic                     fq_mf_i,
    input  logic                     fq_of_i,
    input  logic                     evt_avail_i,
    input  logic                     done_i,
    input  logic                     resp_err_i,
    output logic [31:0]              fq_tail_o,
    output logic                     fq_on_o,
    output logic                     busy_o,
    output logic                     error_wen_o,  // Regmap captures tail, mf and of
    output logic                     fq_mf_o,
    output logic                     fq_of_o,
    output logic                     fq_ip_o,
    output logic                     take_o,
    output logic                     start_o,
    output logic [fq_pkg::PLEN-1:0]  wr_addr_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_ERROR
    } state_e;

    state_e                   state_q, state_n;
    logic                     en_q, en_n;
    logic [31:0]              size_mask;    // Valid index bits
    logic [31:0]              masked_tail;
    logic                     is_full;
    logic [fq_pkg::PLEN-1:0]  addr_q;

    // Shift amount widened so size 31 masks nothing
    assign size_mask   = ~({32{1'b1}} << ({1'b0, fq_size_i} + 6'd1));
    assign masked_tail = fq_tail_i & size_mask;
    assign is_full     = (masked_tail == ((fq_head_i - 32'd1) & size_mask));

    assign busy_o    = (fq_en_i != en_q);  // Enable change still pending
    assign fq_on_o   = en_q | fq_en_i;
    assign wr_addr_o = addr_q;

    always_comb begin
        state_n     = state_q;
        en_n        = en_q;
        fq_tail_o   = fq_tail_i;  // Echo regmap unless written
        fq_mf_o     = fq_mf_i;
        fq_of_o     = fq_of_i;
        error_wen_o = 1'b0;
        fq_ip_o     = 1'b0;
        take_o      = 1'b0;
        start_o     = 1'b0;

        case (state_q)
            ST_IDLE: begin
                if (fq_en_i && !en_q) begin
                    // Fresh enable clears tail and errors
                    fq_tail_o   = '0;
                    fq_mf_o     = 1'b0;
                    fq_of_o     = 1'b0;
                    error_wen_o = 1'b1;
                    en_n        = 1'b1;
                end else if (fq_en_i && evt_avail_i) begin
                    take_o = 1'b1;
                    if (is_full) begin
                        fq_of_o     = 1'b1;  // Record lost
                        error_wen_o = 1'b1;
                        fq_ip_o     = fq_ie_i;
                        state_n     = ST_ERROR;
                    end else begin
                        start_o = 1'b1;
                        state_n = ST_WRITE;
                    end
                end else if (!fq_en_i && en_q) begin
                    en_n = 1'b0;  // Disable only takes effect when idle
                end
            end
            ST_WRITE: begin
                if (done_i) begin
                    error_wen_o = 1'b1;
                    fq_ip_o     = fq_ie_i;
                    if (resp_err_i) begin
                        fq_mf_o = 1'b1;  // Tail kept
                        state_n = ST_ERROR;
                    end else begin
                        fq_tail_o = (fq_tail_i + 32'd1) & size_mask;
                        state_n   = ST_IDLE;
                    end
                end
            end
            ST_ERROR: begin
                // Wait for software to clear both bits
                if (!fq_mf_i && !fq_of_i) begin
                    state_n = ST_IDLE;
                end
            end
            default: state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            en_q    <= 1'b0;
        end else begin
            state_q <= state_n;
            en_q    <= en_n;
        end
    end

    // Record address latched on take
    always_ff @(posedge clk_i) begin
        if (take_o) begin
            addr_q <= {fq_base_ppn_i, 12'b0}
                    | ({{(fq_pkg::PLEN - 32){1'b0}}, masked_tail} << 5);
        end
    end

endmodule

/* fq_event_capture.sv */
`timescale 1ns/100ps

module fq_event_capture #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              event_valid_i,  // Level strobe with one event per rising edge
    input  fq_pkg::fq_event_t evt_i,
    input  logic              take_i,         // Pops the head
    output fq_pkg::fq_event_t evt_o,          // FIFO head
    output logic              evt_avail_o,
    output logic              full_o
);

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    // Event storage
    fq_pkg::fq_event_t mem_q [FIFO_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             strobe_q;  // Strobe level of last cycle
    logic             push, pop;

    assign evt_avail_o = (cnt_q != '0);
    assign full_o      = (cnt_q == CNT_W'(FIFO_DEPTH));

    // Push on a rising edge unless full
    assign push = event_valid_i & ~strobe_q & ~full_o;
    assign pop  = take_i & evt_avail_o;

    assign evt_o = mem_q[rd_ptr_q];  // Registered head seen the cycle after push

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            strobe_q <= 1'b0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            strobe_q <= event_valid_i;
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Count follows net change
            if (push && !pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop && !push) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= evt_i;
        end
    end

endmodule

/* fq_handler.sv */
`timescale 1ns/100ps

module fq_handler #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // Register map
    input  logic [fq_pkg::PPNW-1:0]       fq_base_ppn_i,
    input  logic [4:0]                    fq_size_i,
    input  logic                          fq_en_i,
    input  logic                          fq_ie_i,
    input  logic [31:0]                   fq_head_i,
    input  logic [31:0]                   fq_tail_i,
    input  logic                          fq_mf_i,
    input  logic                          fq_of_i,
    output logic [31:0]                   fq_tail_o,
    output logic                          fq_on_o,
    output logic                          busy_o,
    output logic                          error_wen_o,
    output logic                          fq_mf_o,
    output logic                          fq_of_o,
    output logic                          fq_ip_o,
    // Fault event
    input  logic                          event_valid_i,
    input  logic [fq_pkg::TTYP_LEN-1:0]   trans_type_i,
    input  logic [fq_pkg::CAUSE_LEN-1:0]  cause_code_i,
    input  logic [fq_pkg::XLEN-1:0]       iova_i,
    input  logic [fq_pkg::GPLEN-1:0]      gpaddr_i,
    input  logic [fq_pkg::DID_LEN-1:0]    did_i,
    input  logic                          pv_i,
    input  logic [fq_pkg::PID_LEN-1:0]    pid_i,
    input  logic                          is_supervisor_i,
    input  logic                          is_guest_pf_i,
    input  logic                          is_implicit_i,
    output logic                          full_o,
    // Write bus with AW, W and B only
    output logic                          aw_valid_o,
    output logic [fq_pkg::XLEN-1:0]       aw_addr_o,
    input  logic                          aw_ready_i,
    output logic                          w_valid_o,
    output logic [63:0]                   w_data_o,
    output logic                          w_last_o,
    input  logic                          w_ready_i,
    input  logic                          b_valid_i,
    input  logic [1:0]                    b_resp_i,
    output logic                          b_ready_o
);

    fq_pkg::fq_event_t  evt_in, evt_head;
    logic                     evt_avail, take, start, done, resp_err;
    logic [1:0]               beat;
    logic [63:0]              beat_data;
    logic [fq_pkg::PLEN-1:0]  wr_addr;

    // Pack the loose event fields
    assign evt_in = '{
        ttyp:          trans_type_i,
        cause:         cause_code_i,
        iova:          iova_i,
        gpaddr:        gpaddr_i,
        did:           did_i,
        pv:            pv_i,
        pid:           pid_i,
        is_supervisor: is_supervisor_i,
        is_guest_pf:   is_guest_pf_i,
        is_implicit:   is_implicit_i
    };

    fq_event_capture #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_capture (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .event_valid_i (event_valid_i),
        .evt_i         (evt_in),
        .take_i        (take),
        .evt_o         (evt_head),
        .evt_avail_o   (evt_avail),
        .full_o        (full_o)
    );

    fq_record_builder i_builder (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_i      (take),     // Same pulse that pops the FIFO
        .evt_i       (evt_head),
        .beat_i      (beat),
        .record_o    (),
        .beat_data_o (beat_data)
    );

    fq_ctrl i_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fq_base_ppn_i (fq_base_ppn_i),
        .fq_size_i     (fq_size_i),
        .fq_en_i       (fq_en_i),
        .fq_ie_i       (fq_ie_i),
        .fq_head_i     (fq_head_i),
        .fq_tail_i     (fq_tail_i),
        .fq_mf_i       (fq_mf_i),
        .fq_of_i       (fq_of_i),
        .evt_avail_i   (evt_avail),
        .done_i        (done),
        .resp_err_i    (resp_err),
        .fq_tail_o     (fq_tail_o),
        .fq_on_o       (fq_on_o),
        .busy_o        (busy_o),
        .error_wen_o   (error_wen_o),
        .fq_mf_o       (fq_mf_o),
        .fq_of_o       (fq_of_o),
        .fq_ip_o       (fq_ip_o),
        .take_o        (take),
        .start_o       (start),
        .wr_addr_o     (wr_addr)
    );

    fq_mem_writer i_writer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start),
        .addr_i      (wr_addr),
        .beat_data_i (beat_data),
        .beat_o      (beat),
        .aw_valid_o  (aw_valid_o),
        .aw_addr_o   (aw_addr_o),
        .aw_ready_i  (aw_ready_i),
        .w_valid_o   (w_valid_o),
        .w_data_o    (w_data_o),
        .w_last_o    (w_last_o),
        .w_ready_i   (w_ready_i),
        .b_valid_i   (b_valid_i),
        .b_resp_i    (b_resp_i),
        .b_ready_o   (b_ready_o),
        .done_o      (done),
        .resp_err_o  (resp_err)
    );

endmodule

/* fq_handler_assert.sv */
`timescale 1ns/100ps

module fq_handler_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic aw_valid_o,
    input logic aw_ready_i,
    input logic w_valid_o,
    input logic w_ready_i,
    input logic w_last_o,
    input logic error_wen_o,
    input logic fq_en_i,
    input logic fq_on_o
);

    // Valid held until the handshake
    aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_valid_o && !aw_ready_i |=> aw_valid_o)
        else $error("aw_valid_o dropped before aw_ready_i");

    w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_valid_o && !w_ready_i |=> w_valid_o)
        else $error("w_valid_o dropped before w_ready_i");

    // Accepted last beat ends the burst
    w_last_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_valid_o && w_ready_i && w_last_o |=> !w_valid_o)
        else $error("w_valid_o still high after the last beat");

    // No regmap write while the queue is off
    no_wen_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$past(fq_en_i) && !fq_on_o |-> !error_wen_o)
        else $error("error_wen_o while the queue is off");

endmodule

bind fq_handler fq_handler_assert i_assert (.*);

/* fq_mem_writer.sv */
`timescale 1ns/100ps

module fq_mem_writer (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      start_i,      // One-cycle kick from the controller
    input  logic [fq_pkg::PLEN-1:0]   addr_i,       // Held by the controller during the burst
    input  logic [63:0]               beat_data_i,  // Word for beat_o
    output logic [1:0]                beat_o,
    output logic                      aw_valid_o,
    output logic [fq_pkg::XLEN-1:0]   aw_addr_o,
    input  logic                      aw_ready_i,
    output logic                      w_valid_o,
    output logic [63:0]               w_data_o,
    output logic                      w_last_o,
    input  logic                      w_ready_i,
    input  logic                      b_valid_i,
    input  logic [1:0]                b_resp_i,
    output logic                      b_ready_o,
    output logic                      done_o,       // Response taken
    output logic                      resp_err_o    // Valid with done_o
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e  state_q, state_n;
    logic [1:0] cnt_q, cnt_n;
    logic       last_beat;

    assign last_beat = (cnt_q == 2'(fq_pkg::BEATS - 1));

    // Bus outputs decoded from state
    assign aw_valid_o = (state_q == WR_ADDR);
    assign aw_addr_o  = {{(fq_pkg::XLEN - fq_pkg::PLEN){1'b0}}, addr_i};
    assign w_valid_o  = (state_q == WR_DATA);
    assign w_data_o   = beat_data_i;
    assign w_last_o   = w_valid_o & last_beat;
    assign beat_o     = cnt_q;

    // Response taken in the cycle it arrives
    assign b_ready_o  = (state_q == WR_RESP) & b_valid_i;
    assign done_o     = b_ready_o;
    assign resp_err_o = (b_resp_i != 2'b00);  // Anything but OKAY

    always_comb begin
        state_n = state_q;
        cnt_n   = cnt_q;
        case (state_q)
            WR_IDLE: begin
                if (start_i) begin
                    state_n = WR_ADDR;
                end
            end
            WR_ADDR: begin
                cnt_n = '0;
                if (aw_ready_i) begin
                    state_n = WR_DATA;
                end
            end
            WR_DATA: begin
                if (w_ready_i) begin  // Count only accepted beats
                    cnt_n = cnt_q + 1'b1;
                    if (last_beat) begin
                        state_n = WR_RESP;
                    end
                end
            end
            WR_RESP: begin
                if (b_valid_i) begin
                    state_n = WR_IDLE;
                end
            end
            default: state_n = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= WR_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_n;
            cnt_q   <= cnt_n;
        end
    end

endmodule

/* fq_pkg.sv */
package fq_pkg;

    // Field widths
    localparam int unsigned TTYP_LEN  = 6;   // Transaction type
    localparam int unsigned CAUSE_LEN = 12;  // Fault cause code
    localparam int unsigned XLEN      = 64;  // IOVA, bus address and bus data
    localparam int unsigned GPLEN     = 41;  // Guest physical address
    localparam int unsigned PLEN      = 56;  // Physical address
    localparam int unsigned PPNW      = 44;  // Base page number
    localparam int unsigned DID_LEN   = 24;  // Device ID
    localparam int unsigned PID_LEN   = 20;  // Process ID

    // Data beats per fault record, 8 bytes each
    localparam int unsigned BEATS = 4;

    // Transaction type codes
    localparam logic [TTYP_LEN-1:0] TTYP_NONE     = 6'd0;  // No transaction, e.g. MSI write fault
    localparam logic [TTYP_LEN-1:0] TTYP_PCIE_MSG = 6'd9;  // PCIe message request

    // Event as queued in the capture FIFO
    typedef struct packed {
        logic [TTYP_LEN-1:0]  ttyp;
        logic [CAUSE_LEN-1:0] cause;
        logic [XLEN-1:0]      iova;
        logic [GPLEN-1:0]     gpaddr;
        logic [DID_LEN-1:0]   did;
        logic                 pv;            // pid is valid
        logic [PID_LEN-1:0]   pid;
        logic                 is_supervisor;
        logic                 is_guest_pf;
        logic                 is_implicit;   // GPF from implicit first-stage access
    } fq_event_t;

    // 256-bit fault record, word 0 in the low bits
    typedef struct packed {
        logic [XLEN-1:0]      iotval2;   // Word 3
        logic [XLEN-1:0]      iotval;    // Word 2
        logic [XLEN-1:0]      rsvd;      // Word 1, always zero
        logic [DID_LEN-1:0]   did;       // Word 0 bits 63:40
        logic [TTYP_LEN-1:0]  ttyp;      // Bits 39:34
        logic                 priv;      // Bit 33
        logic                 pv;        // Bit 32
        logic [PID_LEN-1:0]   pid;       // Bits 31:12
        logic [CAUSE_LEN-1:0] cause;     // Bits 11:0
    } fq_record_t;

endpackage

/* fq_record_builder.sv */
`timescale 1ns/100ps

module fq_record_builder (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               load_i,       // Take pulse from the controller
    input  fq_pkg::fq_event_t  evt_i,
    input  logic [1:0]         beat_i,       // Beat being sent on W
    output fq_pkg::fq_record_t record_o,
    output logic [63:0]        beat_data_o
);

    fq_pkg::fq_record_t rec_q, rec_n;

    // Formatting of the next record
    always_comb begin
        rec_n       = '0;
        rec_n.cause = evt_i.cause;
        rec_n.ttyp  = evt_i.ttyp;

        if (evt_i.ttyp != fq_pkg::TTYP_NONE) begin
            rec_n.did  = evt_i.did;
            rec_n.pv   = evt_i.pv;
            rec_n.pid  = evt_i.pv ? evt_i.pid : '0;  // Only with a valid pid
            rec_n.priv = evt_i.pv & evt_i.is_supervisor;
            // Message requests report no address
            if (evt_i.ttyp != fq_pkg::TTYP_PCIE_MSG) begin
                rec_n.iotval = evt_i.iova;
            end
        end else begin
            rec_n.iotval = evt_i.iova;  // Ids and priv stay zero
        end

        // Guest page fault reports GPA bits 63:2
        if (evt_i.is_guest_pf) begin
            rec_n.iotval2    = {{(fq_pkg::XLEN - fq_pkg::GPLEN){1'b0}}, evt_i.gpaddr};
            rec_n.iotval2[0] = evt_i.is_implicit;
            rec_n.iotval2[1] = 1'b0;  // No A/D update
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rec_q <= '0;
        end else if (load_i) begin
            rec_q <= rec_n;
        end
    end

    assign record_o = rec_q;

    // Word select for the current beat
    assign beat_data_o = rec_q[{beat_i, 6'd0} +: 64];

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_fq_handler \
    && ./obj_dir/Vtb_fq_handler \
    || exit 1

/* tb_fq_handler.sv */
`timescale 1ns/100ps

module tb_fq_handler;

    localparam int unsigned FIFO_DEPTH  = 4;
    localparam int unsigned RAND_EVENTS = 16;
    localparam int unsigned N_EVENTS    = RAND_EVENTS + 11;  // Plus directed tests
    localparam int unsigned TIMEOUT     = 40 * N_EVENTS + 200;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic [43:0] fq_base_ppn_i;
    logic [4:0]  fq_size_i;
    logic        fq_en_i, fq_ie_i;
    logic [31:0] fq_head_i = 32'd3;
    logic [31:0] fq_tail_i = 32'd3;  // Regmap model starts nonzero before enable
    logic        fq_mf_i   = 1'b1;
    logic        fq_of_i   = 1'b1;
    logic [31:0] fq_tail_o;
    logic        fq_on_o, busy_o, error_wen_o, fq_mf_o, fq_of_o, fq_ip_o, full_o;
    logic        event_valid_i;
    fq_pkg::fq_event_t ev_drv;   // Fields driven onto the event ports
    logic        aw_valid_o, w_valid_o, w_last_o, b_ready_o;
    logic [63:0] aw_addr_o, w_data_o;
    logic        aw_ready_i = 1'b0;
    logic        w_ready_i  = 1'b0;
    logic        b_valid_i  = 1'b0;
    logic [1:0]  b_resp_i   = 2'b00;

    // Test control
    logic        hold_bus, err_req, head_mode, sw_clear;
    fq_pkg::fq_event_t exp_q[$];   // Events expected on the bus in order
    logic [63:0]  addr_q[$];
    logic [255:0] data_q[$];
    logic [63:0]  cur_addr;
    logic [255:0] cur_data;
    int           beat_idx = 0;
    int           n_aw = 0;
    int           n_rec = 0;
    int           cycles = 0;
    logic [31:0]  exp_tail = 32'd0;  // Own tail count cleared by enable at start
    logic [31:0]  tail_save;
    int           aw_save;

    fq_handler #(.FIFO_DEPTH(FIFO_DEPTH)) i_dut (
        .clk_i, .rst_ni, .fq_base_ppn_i, .fq_size_i, .fq_en_i, .fq_ie_i,
        .fq_head_i, .fq_tail_i, .fq_mf_i, .fq_of_i, .fq_tail_o, .fq_on_o,
        .busy_o, .error_wen_o, .fq_mf_o, .fq_of_o, .fq_ip_o,
        .event_valid_i,
        .trans_type_i    (ev_drv.ttyp),
        .cause_code_i    (ev_drv.cause),
        .iova_i          (ev_drv.iova),
        .gpaddr_i        (ev_drv.gpaddr),
        .did_i           (ev_drv.did),
        .pv_i            (ev_drv.pv),
        .pid_i           (ev_drv.pid),
        .is_supervisor_i (ev_drv.is_supervisor),
        .is_guest_pf_i   (ev_drv.is_guest_pf),
        .is_implicit_i   (ev_drv.is_implicit),
        .full_o,
        .aw_valid_o, .aw_addr_o, .aw_ready_i, .w_valid_o, .w_data_o, .w_last_o,
        .w_ready_i, .b_valid_i, .b_resp_i, .b_ready_o
    );

    always #5 clk_i = ~clk_i;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // Expected record for one event
    function automatic fq_pkg::fq_record_t ref_record(input fq_pkg::fq_event_t e);
        fq_pkg::fq_record_t r;
        r       = '0;
        r.cause = e.cause;
        r.ttyp  = e.ttyp;
        if (e.ttyp == 6'd0) begin
            r.iotval = e.iova;
        end else begin
            r.did    = e.did;
            r.pv     = e.pv;
            r.pid    = e.pv ? e.pid : 20'd0;
            r.priv   = e.pv && e.is_supervisor;
            r.iotval = (e.ttyp == 6'd9) ? 64'd0 : e.iova;
        end
        if (e.is_guest_pf) begin
            r.iotval2 = {23'd0, e.gpaddr[40:2], 1'b0, e.is_implicit};
        end
        return r;
    endfunction

    function automatic logic [31:0] size_mask();
        return (32'd1 << (fq_size_i + 5'd1)) - 32'd1;
    endfunction

    function automatic fq_pkg::fq_event_t rand_event();
        fq_pkg::fq_event_t e;
        logic [63:0] gpa;
        case ($urandom % 4)
            0:       e.ttyp = 6'd0;                      // None
            1:       e.ttyp = 6'd9;                      // Message request
            default: e.ttyp = 6'(1 + ($urandom % 8));    // Translated kinds
        endcase
        gpa             = {$urandom, $urandom};
        e.cause         = 12'($urandom);
        e.iova          = {$urandom, $urandom};
        e.gpaddr        = gpa[40:0];
        e.did           = 24'($urandom);
        e.pv            = 1'($urandom);
        e.pid           = 20'($urandom);
        e.is_supervisor = 1'($urandom);
        e.is_guest_pf   = 1'($urandom);
        e.is_implicit   = 1'($urandom);
        return e;
    endfunction

    // One rising edge of the strobe held for hold cycles
    task automatic send_event(input fq_pkg::fq_event_t e, input int hold);
        @(posedge clk_i);
        ev_drv        <= e;
        event_valid_i <= 1'b1;
        fq_ie_i       <= 1'($urandom);
        exp_q.push_back(e);
        repeat (hold) @(posedge clk_i);
        event_valid_i <= 1'b0;
    endtask

    task automatic wait_records(input int target);
        do @(negedge clk_i); while (n_rec < target || b_valid_i);
    endtask

    task automatic clear_errors();
        @(posedge clk_i);
        sw_clear <= 1'b1;
        @(posedge clk_i);
        sw_clear <= 1'b0;
    endtask

    // Register map model where head follows tail like an instant consumer
    always @(posedge clk_i) begin
        if (sw_clear) begin
            fq_mf_i <= 1'b0;
            fq_of_i <= 1'b0;
        end else if (error_wen_o) begin
            fq_tail_i <= fq_tail_o;
            fq_mf_i   <= fq_mf_o;
            fq_of_i   <= fq_of_o;
        end
        fq_head_i <= head_mode ? fq_tail_i + 32'd1 : fq_tail_i;
        if (rst_ni) begin
            check("fq_ip_o without fq_ie_i", fq_ip_o & ~fq_ie_i, 0);
        end
    end

    // Memory responder with random ready
    always @(posedge clk_i) begin
        if (rst_ni) begin
            aw_ready_i <= !hold_bus && ($urandom % 4 != 0);
            w_ready_i  <= !hold_bus && ($urandom % 4 != 0);
            if (aw_valid_o && aw_ready_i) begin
                cur_addr = aw_addr_o;
                n_aw++;
            end
            if (w_valid_o && w_ready_i) begin
                cur_data[beat_idx*64 +: 64] = w_data_o;
                check("w_last_o", w_last_o, beat_idx == 3);
                if (w_last_o) begin
                    addr_q.push_back(cur_addr);
                    data_q.push_back(cur_data);
                    n_rec++;
                    beat_idx = 0;
                    b_valid_i <= 1'b1;
                    b_resp_i  <= err_req ? 2'b10 : 2'b00;  // SLVERR on request
                end else begin
                    beat_idx++;
                end
            end
            if (b_valid_i && b_ready_o) begin
                b_valid_i <= 1'b0;
                check("error_wen_o", error_wen_o, 1);
                check("fq_ip_o", fq_ip_o, fq_ie_i);
                if (b_resp_i == 2'b00) begin
                    exp_tail = (exp_tail + 32'd1) & size_mask();
                end
                check("fq_mf_o", fq_mf_o, b_resp_i != 2'b00);
                check("fq_of_o", fq_of_o, 0);
                check("fq_tail_o", fq_tail_o, exp_tail);
            end
        end
    end

    // Compare each finished burst with the reference record
    always @(negedge clk_i) begin : compare
        logic [63:0]        got_addr;
        logic [255:0]       got_data;
        fq_pkg::fq_record_t exp_rec;
        if (addr_q.size() > 0) begin
            got_addr = addr_q.pop_front();
            got_data = data_q.pop_front();
            if (exp_q.size() == 0) begin
                $display("A burst was written with no event pending");
                $display("Verification failed");
                $fatal(1);
            end
            exp_rec = ref_record(exp_q.pop_front());
            check("aw_addr_o", got_addr,
                  {8'd0, fq_base_ppn_i, 12'd0} + 64'(exp_tail) * 64'd32);
            for (int k = 0; k < 4; k++) begin
                check($sformatf("w_data_o beat %0d", k), got_data[k*64 +: 64],
                      exp_rec[k*64 +: 64]);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Verification failed");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(32'h28e7));
        rst_ni        = 1'b0;
        fq_base_ppn_i = {12'h0, $urandom};
        fq_size_i     = 5'd1;  // Four entries so the tail wraps at 4
        fq_en_i       = 1'b0;
        fq_ie_i       = 1'b0;
        event_valid_i = 1'b0;
        ev_drv        = '0;
        hold_bus      = 1'b0;
        err_req       = 1'b0;
        head_mode     = 1'b0;
        sw_clear      = 1'b0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);

        // Enable clears tail and errors
        fq_en_i <= 1'b1;
        @(negedge clk_i);
        check("busy_o", busy_o, 1);
        check("fq_on_o", fq_on_o, 1);
        @(negedge clk_i);
        check("busy_o", busy_o, 0);
        check("fq_on_o", fq_on_o, 1);
        check("fq_tail_i", fq_tail_i, 0);
        check("fq_mf_i", fq_mf_i, 0);
        check("fq_of_i", fq_of_i, 0);

        // Random records over several wraps of the tail
        for (int i = 0; i < RAND_EVENTS; i++) begin
            send_event(rand_event(), 1);
            wait_records(i + 1);
        end
        check("fq_tail_i", fq_tail_i, exp_tail);

        // Long strobe gives one record
        send_event(rand_event(), 20);
        wait_records(RAND_EVENTS + 1);
        repeat (20) @(posedge clk_i);
        check("records after long strobe", n_rec, RAND_EVENTS + 1);

        // Queue up while the bus is stalled
        hold_bus <= 1'b1;
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            send_event(rand_event(), 1);
        end
        @(negedge clk_i);
        check("full_o", full_o, 1);
        hold_bus <= 1'b0;
        wait_records(RAND_EVENTS + FIFO_DEPTH + 2);

        // Overflow drops the record
        aw_save = n_aw;
        head_mode <= 1'b1;
        send_event(rand_event(), 1);
        do @(negedge clk_i); while (!fq_of_i);
        void'(exp_q.pop_front());
        send_event(rand_event(), 1);
        repeat (20) @(posedge clk_i);
        check("aw count during overflow", n_aw, aw_save);
        head_mode <= 1'b0;
        clear_errors();
        wait_records(n_rec + 1);

        // Bus error keeps the tail
        tail_save = fq_tail_i;
        err_req <= 1'b1;
        send_event(rand_event(), 1);
        do @(negedge clk_i); while (!fq_mf_i);
        check("fq_tail_i after bus error", fq_tail_i, tail_save);
        err_req <= 1'b0;
        aw_save = n_aw;
        send_event(rand_event(), 1);
        repeat (20) @(posedge clk_i);
        check("aw count during memory fault", n_aw, aw_save);
        clear_errors();
        wait_records(n_rec + 1);

        // Events stay off the bus after disable
        @(posedge clk_i);
        fq_en_i <= 1'b0;
        @(negedge clk_i);
        check("busy_o", busy_o, 1);
        @(negedge clk_i);
        check("busy_o", busy_o, 0);
        check("fq_on_o", fq_on_o, 0);
        aw_save = n_aw;
        send_event(rand_event(), 1);
        repeat (30) @(posedge clk_i);
        check("aw count while disabled", n_aw, aw_save);
        void'(exp_q.pop_back());

        if (exp_q.size() != 0) begin
            $display("Events were never written: %0d left", exp_q.size());
            $display("Verification failed");
            $fatal(1);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule
